/* compile.f */
+incdir+src
src/cu_pkg.sv
src/cu_sequencer.sv
src/cu_alu_decode.sv
src/cu_flow_decode.sv
src/control_unit.sv
verif/control_unit_checker.sv
verif/control_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the control unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module control_unit_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Raise the error limit so assertion failures reach the testbench summary
sim_out=$(./obj_dir/Vcontrol_unit_tb +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1

/* src/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module control_unit (
  input  logic                    CU_CLK,
  input  logic                    CU_RESET,
  input  logic                    cu_c,
  input  logic                    cu_z,
  input  logic                    cu_int,
  input  logic [`CU_OPC_HI_W-1:0] cu_opcode_hi_5,
  input  logic [`CU_OPC_LO_W-1:0] cu_opcode_lo_2,
  output logic                    cu_rst,
  output logic                    cu_pc_inc,
  output logic [3:0]              cu_alu_sel,
  output logic                    cu_alu_opy_sel,
  output logic                    cu_rf_wr,
  output logic [1:0]              cu_rf_wr_sel,
  output logic                    cu_flg_c_ld,
  output logic                    cu_flg_c_clr,
  output logic                    cu_flg_c_set,
  output logic                    cu_flg_z_ld,
  output logic                    cu_flg_ld_sel,
  output logic                    cu_pc_ld,
  output logic [1:0]              cu_pc_mux_sel,
  output logic                    cu_sp_incr,
  output logic                    cu_sp_decr,
  output logic                    cu_scr_we,
  output logic                    cu_scr_data_sel,
  output logic [1:0]              cu_scr_addr_sel,
  output logic                    cu_i_set,
  output logic                    cu_i_clr,
  output logic                    cu_flg_shad_ld
);

  import cu_pkg::*;

  cu_instr_u instr;
  logic      init;
  logic      fetch;
  logic      exec;
  logic      intr;

  assign instr.opcode = {cu_opcode_hi_5, cu_opcode_lo_2};

  assign cu_rst    = init;     // Datapath reset pulse
  assign cu_pc_inc = fetch;

  cu_sequencer cu_sequencer_inst (
    .CU_CLK   (CU_CLK),
    .CU_RESET (CU_RESET),
    .cu_int   (cu_int),
    .init     (init),
    .fetch    (fetch),
    .exec     (exec),
    .intr     (intr)
  );

  cu_alu_decode cu_alu_decode_inst (
    .exec        (exec),
    .instr       (instr),
    .alu_sel     (cu_alu_sel),
    .alu_opy_sel (cu_alu_opy_sel),
    .rf_wr       (cu_rf_wr),
    .rf_wr_sel   (cu_rf_wr_sel),
    .flg_c_ld    (cu_flg_c_ld),
    .flg_c_clr   (cu_flg_c_clr),
    .flg_c_set   (cu_flg_c_set),
    .flg_z_ld    (cu_flg_z_ld),
    .flg_ld_sel  (cu_flg_ld_sel)
  );

  cu_flow_decode cu_flow_decode_inst (
    .exec         (exec),
    .intr         (intr),
    .cu_c         (cu_c),
    .cu_z         (cu_z),
    .instr        (instr),
    .pc_ld        (cu_pc_ld),
    .pc_mux_sel   (cu_pc_mux_sel),
    .sp_incr      (cu_sp_incr),
    .sp_decr      (cu_sp_decr),
    .scr_we       (cu_scr_we),
    .scr_data_sel (cu_scr_data_sel),
    .scr_addr_sel (cu_scr_addr_sel),
    .i_set        (cu_i_set),
    .i_clr        (cu_i_clr),
    .flg_shad_ld  (cu_flg_shad_ld)
  );

endmodule

`default_nettype wire

/* src/cu_alu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module cu_alu_decode (
  input  logic             exec,
  input  cu_pkg::cu_instr_u instr,
  output logic [3:0]       alu_sel,
  output logic             alu_opy_sel,
  output logic             rf_wr,
  output logic [1:0]       rf_wr_sel,
  output logic             flg_c_ld,
  output logic             flg_c_clr,
  output logic             flg_c_set,
  output logic             flg_z_ld,
  output logic             flg_ld_sel
);

  import cu_pkg::*;

  logic       alu_hit;
  logic [3:0] alu_op;

  ////////////////////////////////////////
  // Opcode to ALU function
  always_comb begin
    alu_hit = 1'b1;
    alu_op  = `CU_ALU_ADD;
    if (instr.ri.major[4]) begin              // RI forms
      case (instr.ri.major)
        5'b10000: alu_op = `CU_ALU_AND;
        5'b10001: alu_op = `CU_ALU_OR;
        5'b10010: alu_op = `CU_ALU_EXOR;
        5'b10011: alu_op = `CU_ALU_TEST;
        5'b10100: alu_op = `CU_ALU_ADD;
        5'b10101: alu_op = `CU_ALU_ADDC;
        5'b10110: alu_op = `CU_ALU_SUB;
        5'b10111: alu_op = `CU_ALU_SUBC;
        5'b11000: alu_op = `CU_ALU_CMP;
        5'b11011: alu_op = `CU_ALU_MOV;
        default:  alu_hit = 1'b0;
      endcase
    end else begin
      case (instr.opcode)
        7'b0000000: alu_op = `CU_ALU_AND;
        7'b0000001: alu_op = `CU_ALU_OR;
        7'b0000010: alu_op = `CU_ALU_EXOR;
        7'b0000011: alu_op = `CU_ALU_TEST;
        7'b0000100: alu_op = `CU_ALU_ADD;
        7'b0000101: alu_op = `CU_ALU_ADDC;
        7'b0000110: alu_op = `CU_ALU_SUB;
        7'b0000111: alu_op = `CU_ALU_SUBC;
        7'b0001000: alu_op = `CU_ALU_CMP;
        7'b0001001: alu_op = `CU_ALU_MOV;
        7'b0100000: alu_op = `CU_ALU_LSL;
        7'b0100001: alu_op = `CU_ALU_LSR;
        7'b0100010: alu_op = `CU_ALU_ROL;
        7'b0100011: alu_op = `CU_ALU_ROR;
        7'b0100100: alu_op = `CU_ALU_ASR;
        default:    alu_hit = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Write and flag strobes
  always_comb begin
    alu_sel     = `CU_ALU_ADD;
    alu_opy_sel = 1'b0;
    rf_wr       = 1'b0;
    rf_wr_sel   = `CU_RF_FROM_ALU;
    flg_c_ld    = 1'b0;
    flg_c_clr   = 1'b0;
    flg_c_set   = 1'b0;
    flg_z_ld    = 1'b0;
    flg_ld_sel  = 1'b0;

    if (exec) begin
      if (alu_hit) begin
        alu_sel     = alu_op;
        alu_opy_sel = instr.ri.major[4];
        case (alu_op)
          `CU_ALU_CMP: begin                  // Flags only
            flg_c_ld = 1'b1;
            flg_z_ld = 1'b1;
          end
          `CU_ALU_TEST: begin
            flg_c_clr = 1'b1;
            flg_z_ld  = 1'b1;
          end
          `CU_ALU_AND, `CU_ALU_OR, `CU_ALU_EXOR: begin
            rf_wr     = 1'b1;
            flg_c_clr = 1'b1;
            flg_z_ld  = 1'b1;
          end
          `CU_ALU_MOV: rf_wr = 1'b1;
          default: begin                      // Arithmetic and shifts
            rf_wr    = 1'b1;
            flg_c_ld = 1'b1;
            flg_z_ld = 1'b1;
          end
        endcase
      end

      if (instr.ri.major == 5'b11100 ||       // LD RI
          instr.opcode == 7'b0001010 ||       // LD RR
          instr.opcode == 7'b0100110) begin   // POP
        rf_wr     = 1'b1;
        rf_wr_sel = `CU_RF_FROM_SCR;
      end

      case (instr.opcode)
        7'b0110110, 7'b0110111: begin         // RETID, RETIE restore flags
          flg_ld_sel = 1'b1;
          flg_c_ld   = 1'b1;
          flg_z_ld   = 1'b1;
        end
        7'b0110000: flg_c_clr = 1'b1;         // CLC
        7'b0110001: flg_c_set = 1'b1;         // SEC
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/cu_defs.svh */
`ifndef CU_DEFS_SVH
`define CU_DEFS_SVH

////////////////////////////////////////
// Opcode fields
`define CU_OPC_W      7
`define CU_OPC_HI_W   5
`define CU_OPC_LO_W   2

// Sequencer state codes
`define CU_ST_INIT    2'b00
`define CU_ST_FETCH   2'b01
`define CU_ST_EXEC    2'b10
`define CU_ST_INTR    2'b11

////////////////////////////////////////
// ALU function selects
`define CU_ALU_ADD    4'd0
`define CU_ALU_ADDC   4'd1
`define CU_ALU_SUB    4'd2
`define CU_ALU_SUBC   4'd3
`define CU_ALU_CMP    4'd4
`define CU_ALU_AND    4'd5
`define CU_ALU_OR     4'd6
`define CU_ALU_EXOR   4'd7
`define CU_ALU_TEST   4'd8
`define CU_ALU_LSL    4'd9
`define CU_ALU_LSR    4'd10
`define CU_ALU_ROL    4'd11
`define CU_ALU_ROR    4'd12
`define CU_ALU_ASR    4'd13
`define CU_ALU_MOV    4'd14

////////////////////////////////////////
// Datapath mux selects
`define CU_PC_FROM_IMM     2'd0
`define CU_PC_FROM_STACK   2'd1
`define CU_PC_FROM_VECTOR  2'd2

`define CU_RF_FROM_ALU     2'd0
`define CU_RF_FROM_SCR     2'd1

`define CU_SCR_BY_REG      2'd0
`define CU_SCR_BY_IMM      2'd1
`define CU_SCR_BY_SP       2'd2
`define CU_SCR_BY_SP_DEC   2'd3  // Address is SP-1

`endif

/* src/cu_flow_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module cu_flow_decode (
  input  logic             exec,
  input  logic             intr,
  input  logic             cu_c,
  input  logic             cu_z,
  input  cu_pkg::cu_instr_u instr,
  output logic             pc_ld,
  output logic [1:0]       pc_mux_sel,
  output logic             sp_incr,
  output logic             sp_decr,
  output logic             scr_we,
  output logic             scr_data_sel,
  output logic [1:0]       scr_addr_sel,
  output logic             i_set,
  output logic             i_clr,
  output logic             flg_shad_ld
);

  import cu_pkg::*;

  always_comb begin
    pc_ld        = 1'b0;
    pc_mux_sel   = `CU_PC_FROM_IMM;
    sp_incr      = 1'b0;
    sp_decr      = 1'b0;
    scr_we       = 1'b0;
    scr_data_sel = 1'b0;
    scr_addr_sel = `CU_SCR_BY_REG;
    i_set        = 1'b0;
    i_clr        = 1'b0;
    flg_shad_ld  = 1'b0;

    ////////////////////////////////////////
    // Interrupt entry
    if (intr) begin
      flg_shad_ld  = 1'b1;
      pc_ld        = 1'b1;
      pc_mux_sel   = `CU_PC_FROM_VECTOR;
      sp_decr      = 1'b1;
      scr_we       = 1'b1;
      scr_data_sel = 1'b1;                    // Push return PC
      scr_addr_sel = `CU_SCR_BY_SP_DEC;
      i_clr        = 1'b1;

    ////////////////////////////////////////
    // Execute
    end else if (exec) begin
      if (instr.ri.major[4]) begin
        case (instr.ri.major)
          5'b11100: scr_addr_sel = `CU_SCR_BY_IMM;   // LD RI
          5'b11101: begin                            // ST RI
            scr_we       = 1'b1;
            scr_addr_sel = `CU_SCR_BY_IMM;
          end
          default: ;
        endcase
      end else begin
        case (instr.opcode)
          7'b0010000: pc_ld = 1'b1;           // BRN
          7'b0010010: pc_ld = cu_z;           // BREQ
          7'b0010011: pc_ld = ~cu_z;          // BRNE
          7'b0010100: pc_ld = cu_c;           // BRCS
          7'b0010101: pc_ld = ~cu_c;          // BRCC
          7'b0010001: begin                   // CALL
            pc_ld        = 1'b1;
            sp_decr      = 1'b1;
            scr_we       = 1'b1;
            scr_data_sel = 1'b1;
            scr_addr_sel = `CU_SCR_BY_SP_DEC;
          end
          7'b0100101: begin                   // PUSH
            sp_decr      = 1'b1;
            scr_we       = 1'b1;
            scr_addr_sel = `CU_SCR_BY_SP_DEC;
          end
          7'b0100110: begin                   // POP
            sp_incr      = 1'b1;
            scr_addr_sel = `CU_SCR_BY_SP;
          end
          7'b0110010, 7'b0110110, 7'b0110111: begin  // RET, RETID, RETIE
            pc_ld        = 1'b1;
            pc_mux_sel   = `CU_PC_FROM_STACK;
            sp_incr      = 1'b1;
            scr_addr_sel = `CU_SCR_BY_SP;
            i_clr        = (instr.opcode == 7'b0110110);
            i_set        = (instr.opcode == 7'b0110111);
          end
          7'b0110101: i_clr  = 1'b1;          // CLI
          7'b0110100: i_set  = 1'b1;          // SEI
          7'b0001011: scr_we = 1'b1;          // ST RR, address from register
          default: ;                          // LD RR uses the default address
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* src/cu_pkg.sv */
`default_nettype none

`include "cu_defs.svh"

package cu_pkg;

  // One instruction word, two decodes
  typedef union packed {
    logic [`CU_OPC_W-1:0] opcode;           // RR and implied forms
    struct packed {
      logic [`CU_OPC_HI_W-1:0] major;       // RI forms match here
      logic [`CU_OPC_LO_W-1:0] minor;       // Immediate bits, ignored
    } ri;
  } cu_instr_u;

endpackage

`default_nettype wire

/* src/cu_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module cu_sequencer (
  input  logic CU_CLK,
  input  logic CU_RESET,
  input  logic cu_int,
  output logic init,
  output logic fetch,
  output logic exec,
  output logic intr
);

  logic [1:0] state;
  logic [1:0] state_nxt;

  always_ff @(posedge CU_CLK) begin
    if (CU_RESET) begin
      state <= `CU_ST_INIT;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    case (state)
      `CU_ST_INIT:  state_nxt = `CU_ST_FETCH;
      `CU_ST_FETCH: state_nxt = `CU_ST_EXEC;
      `CU_ST_EXEC:  state_nxt = cu_int ? `CU_ST_INTR : `CU_ST_FETCH;  // Take interrupt
      `CU_ST_INTR:  state_nxt = `CU_ST_FETCH;
      default:      state_nxt = `CU_ST_INIT;   // Recover
    endcase
  end

  // One-hot phase flags
  assign init  = (state == `CU_ST_INIT);
  assign fetch = (state == `CU_ST_FETCH);
  assign exec  = (state == `CU_ST_EXEC);
  assign intr  = (state == `CU_ST_INTR);

endmodule

`default_nettype wire

/* verif/control_unit_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit_checker (
  input logic CU_CLK,
  input logic CU_RESET,
  input logic cu_int,
  input logic init,
  input logic fetch,
  input logic exec,
  input logic intr,
  input logic cu_sp_incr,
  input logic cu_sp_decr,
  input logic cu_i_set,
  input logic cu_i_clr
);

  int unsigned fail_count = 0;

  ////////////////////////////////////////
  a_one_phase: assert property (@(posedge CU_CLK) disable iff (CU_RESET)
    $onehot({init, fetch, exec, intr}))
    else begin
      fail_count++;
      $error("Sequencer phase flags are not one-hot");
    end

  a_sp_excl: assert property (@(posedge CU_CLK) disable iff (CU_RESET)
    !(cu_sp_incr && cu_sp_decr))
    else begin
      fail_count++;
      $error("SP increment and decrement both high");
    end

  a_i_excl: assert property (@(posedge CU_CLK) disable iff (CU_RESET)
    !(cu_i_set && cu_i_clr))
    else begin
      fail_count++;
      $error("I set and clear both high");
    end

  // Interrupt entry only out of exec with a request
  a_intr_entry: assert property (@(posedge CU_CLK) disable iff (CU_RESET)
    intr |-> $past(exec && cu_int))
    else begin
      fail_count++;
      $error("Interrupt cycle without exec and cu_int before it");
    end

endmodule

bind control_unit control_unit_checker checker_inst (
  .CU_CLK     (CU_CLK),
  .CU_RESET   (CU_RESET),
  .cu_int     (cu_int),
  .init       (init),
  .fetch      (fetch),
  .exec       (exec),
  .intr       (intr),
  .cu_sp_incr (cu_sp_incr),
  .cu_sp_decr (cu_sp_decr),
  .cu_i_set   (cu_i_set),
  .cu_i_clr   (cu_i_clr)
);

`default_nettype wire

/* verif/control_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_defs.svh"

module control_unit_tb;

  logic       CU_CLK;
  logic       CU_RESET;
  logic       cu_c;
  logic       cu_z;
  logic       cu_int;
  logic [4:0] cu_opcode_hi_5;
  logic [1:0] cu_opcode_lo_2;
  logic       cu_rst;
  logic       cu_pc_inc;
  logic [3:0] cu_alu_sel;
  logic       cu_alu_opy_sel;
  logic       cu_rf_wr;
  logic [1:0] cu_rf_wr_sel;
  logic       cu_flg_c_ld;
  logic       cu_flg_c_clr;
  logic       cu_flg_c_set;
  logic       cu_flg_z_ld;
  logic       cu_flg_ld_sel;
  logic       cu_pc_ld;
  logic [1:0] cu_pc_mux_sel;
  logic       cu_sp_incr;
  logic       cu_sp_decr;
  logic       cu_scr_we;
  logic       cu_scr_data_sel;
  logic [1:0] cu_scr_addr_sel;
  logic       cu_i_set;
  logic       cu_i_clr;
  logic       cu_flg_shad_ld;

  // Vectors from the data file
  string      vec_name[$];
  logic [6:0] vec_opc[$];
  logic       vec_c[$];
  logic       vec_z[$];
  logic       vec_int[$];
  logic [3:0] vec_alu_sel[$];
  logic [8:0] vec_alu_stb[$];          // opy, wr, wr_sel[2], c_ld, c_clr, c_set, z_ld, ld_sel
  logic [1:0] vec_pc_sel[$];
  logic [1:0] vec_scr_sel[$];
  logic [7:0] vec_flow_stb[$];         // pc_ld, sp_inc, sp_dec, we, data, i_set, i_clr, shad

  int   error_count = 0;
  int   tests_ok = 0;
  int   tests_bad = 0;
  int   cycle_count = 0;
  int   cycle_limit = 0;
  logic load_ok = 1'b1;

  control_unit control_unit_inst (
    .CU_CLK          (CU_CLK),
    .CU_RESET        (CU_RESET),
    .cu_c            (cu_c),
    .cu_z            (cu_z),
    .cu_int          (cu_int),
    .cu_opcode_hi_5  (cu_opcode_hi_5),
    .cu_opcode_lo_2  (cu_opcode_lo_2),
    .cu_rst          (cu_rst),
    .cu_pc_inc       (cu_pc_inc),
    .cu_alu_sel      (cu_alu_sel),
    .cu_alu_opy_sel  (cu_alu_opy_sel),
    .cu_rf_wr        (cu_rf_wr),
    .cu_rf_wr_sel    (cu_rf_wr_sel),
    .cu_flg_c_ld     (cu_flg_c_ld),
    .cu_flg_c_clr    (cu_flg_c_clr),
    .cu_flg_c_set    (cu_flg_c_set),
    .cu_flg_z_ld     (cu_flg_z_ld),
    .cu_flg_ld_sel   (cu_flg_ld_sel),
    .cu_pc_ld        (cu_pc_ld),
    .cu_pc_mux_sel   (cu_pc_mux_sel),
    .cu_sp_incr      (cu_sp_incr),
    .cu_sp_decr      (cu_sp_decr),
    .cu_scr_we       (cu_scr_we),
    .cu_scr_data_sel (cu_scr_data_sel),
    .cu_scr_addr_sel (cu_scr_addr_sel),
    .cu_i_set        (cu_i_set),
    .cu_i_clr        (cu_i_clr),
    .cu_flg_shad_ld  (cu_flg_shad_ld)
  );

  initial begin
    CU_CLK = 1'b0;
    forever #20 CU_CLK = ~CU_CLK;
  end

  ////////////////////////////////////////
  // Compare tasks

  task automatic check_alu(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: cu_alu_sel expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_sel(input string name, input string sig,
                           input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h actual %h", name, sig, exp, act);
      error_count++;
    end
  endtask

  task automatic check_strobe(input string name, input string sig,
                              input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %b actual %b", name, sig, exp, act);
      error_count++;
    end
  endtask

  task automatic check_alu_side(input string name, input logic [3:0] exp_sel,
                                input logic [8:0] exp_stb);
    check_alu(name, exp_sel, cu_alu_sel);
    check_strobe(name, "cu_alu_opy_sel", exp_stb[8], cu_alu_opy_sel);
    check_strobe(name, "cu_rf_wr", exp_stb[7], cu_rf_wr);
    check_sel(name, "cu_rf_wr_sel", exp_stb[6:5], cu_rf_wr_sel);
    check_strobe(name, "cu_flg_c_ld", exp_stb[4], cu_flg_c_ld);
    check_strobe(name, "cu_flg_c_clr", exp_stb[3], cu_flg_c_clr);
    check_strobe(name, "cu_flg_c_set", exp_stb[2], cu_flg_c_set);
    check_strobe(name, "cu_flg_z_ld", exp_stb[1], cu_flg_z_ld);
    check_strobe(name, "cu_flg_ld_sel", exp_stb[0], cu_flg_ld_sel);
  endtask

  task automatic check_flow_side(input string name, input logic [1:0] exp_pc,
                                 input logic [1:0] exp_scr, input logic [7:0] exp_stb);
    check_sel(name, "cu_pc_mux_sel", exp_pc, cu_pc_mux_sel);
    check_sel(name, "cu_scr_addr_sel", exp_scr, cu_scr_addr_sel);
    check_strobe(name, "cu_pc_ld", exp_stb[7], cu_pc_ld);
    check_strobe(name, "cu_sp_incr", exp_stb[6], cu_sp_incr);
    check_strobe(name, "cu_sp_decr", exp_stb[5], cu_sp_decr);
    check_strobe(name, "cu_scr_we", exp_stb[4], cu_scr_we);
    check_strobe(name, "cu_scr_data_sel", exp_stb[3], cu_scr_data_sel);
    check_strobe(name, "cu_i_set", exp_stb[2], cu_i_set);
    check_strobe(name, "cu_i_clr", exp_stb[1], cu_i_clr);
    check_strobe(name, "cu_flg_shad_ld", exp_stb[0], cu_flg_shad_ld);
  endtask

  // Init and fetch cycles drive nothing but cu_rst or cu_pc_inc
  task automatic check_quiet(input string name, input logic exp_rst, input logic exp_inc);
    check_strobe(name, "cu_rst", exp_rst, cu_rst);
    check_strobe(name, "cu_pc_inc", exp_inc, cu_pc_inc);
    check_alu_side(name, 4'd0, 9'b0);
    check_flow_side(name, 2'd0, 2'd0, 8'b0);
  endtask

  ////////////////////////////////////////
  // Vector file and test sequence

  task automatic load_vectors();
    int         fd;
    int         got;
    string      tok;
    string      rest;
    logic [6:0] opc;
    logic       c_in;
    logic       z_in;
    logic       int_in;
    logic [3:0] alu_sel;
    logic [8:0] alu_stb;
    logic [1:0] pc_sel;
    logic [1:0] scr_sel;
    logic [7:0] flow_stb;
    fd = $fopen("verif/control_unit_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the test data file verif/control_unit_testdata.txt");
      load_ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        got = $fscanf(fd, "%s", tok);
        if (got == 1) begin
          if (tok.getc(0) == "#") begin
            got = $fgets(rest, fd);                 // Column notes
          end else begin
            got = $fscanf(fd, "%h %b %b %b %h %b %h %h %b", opc, c_in, z_in, int_in,
                          alu_sel, alu_stb, pc_sel, scr_sel, flow_stb);
            if (got != 9) begin
              $display("Test data line for %s is malformed", tok);
              load_ok = 1'b0;
            end else begin
              vec_name.push_back(tok);
              vec_opc.push_back(opc);
              vec_c.push_back(c_in);
              vec_z.push_back(z_in);
              vec_int.push_back(int_in);
              vec_alu_sel.push_back(alu_sel);
              vec_alu_stb.push_back(alu_stb);
              vec_pc_sel.push_back(pc_sel);
              vec_scr_sel.push_back(scr_sel);
              vec_flow_stb.push_back(flow_stb);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (error_count == errs_before) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d mismatches", name, error_count - errs_before);
    end
  endtask

  task automatic run_vector(input int idx);
    string name;
    int    errs_before;
    name        = vec_name[idx];
    errs_before = error_count;
    while (cu_pc_inc !== 1'b1) @(negedge CU_CLK);   // Wait for fetch
    check_quiet({name, " fetch"}, 1'b0, 1'b1);
    @(posedge CU_CLK);
    cu_opcode_hi_5 <= vec_opc[idx][6:2];
    cu_opcode_lo_2 <= vec_opc[idx][1:0];
    cu_c           <= vec_c[idx];
    cu_z           <= vec_z[idx];
    cu_int         <= vec_int[idx];
    @(negedge CU_CLK);                               // Exec cycle
    check_strobe(name, "cu_rst", 1'b0, cu_rst);
    check_strobe(name, "cu_pc_inc", 1'b0, cu_pc_inc);
    check_alu_side(name, vec_alu_sel[idx], vec_alu_stb[idx]);
    check_flow_side(name, vec_pc_sel[idx], vec_scr_sel[idx], vec_flow_stb[idx]);
    @(posedge CU_CLK);
    cu_int <= 1'b0;
    @(negedge CU_CLK);
    if (vec_int[idx]) begin
      // Interrupt entry pushes PC, jumps to the vector, masks I
      check_strobe({name, " intr"}, "cu_rst", 1'b0, cu_rst);
      check_strobe({name, " intr"}, "cu_pc_inc", 1'b0, cu_pc_inc);
      check_alu_side({name, " intr"}, 4'd0, 9'b0);
      check_flow_side({name, " intr"}, `CU_PC_FROM_VECTOR, `CU_SCR_BY_SP_DEC, 8'b10111011);
      @(negedge CU_CLK);
    end
    check_quiet({name, " next"}, 1'b0, 1'b1);
    report_test(name, errs_before);
  endtask

  initial begin
    int errs_before;
    int assert_fails;
    CU_RESET       = 1'b1;
    cu_c           = 1'b0;
    cu_z           = 1'b0;
    cu_int         = 1'b0;
    cu_opcode_hi_5 = 5'b0;
    cu_opcode_lo_2 = 2'b0;
    load_vectors();
    cycle_limit = 3 * vec_name.size() + 10;
    if (!load_ok) begin
      error_count++;
    end else begin
      repeat (2) @(posedge CU_CLK);
      CU_RESET <= 1'b0;
      errs_before = error_count;
      @(negedge CU_CLK);
      check_quiet("reset init", 1'b1, 1'b0);
      @(negedge CU_CLK);
      check_quiet("reset fetch", 1'b0, 1'b1);
      report_test("reset", errs_before);
      for (int i = 0; i < vec_name.size(); i++) begin
        run_vector(i);
      end
    end
    assert_fails = int'(control_unit_inst.checker_inst.fail_count);
    $display("Tests ok %0d, failed %0d, mismatches %0d, assertion failures %0d",
             tests_ok, tests_bad, error_count, assert_fails);
    if (error_count == 0 && tests_bad == 0 && assert_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Run limit
  initial begin
    wait (cycle_limit != 0);
    while (cycle_count <= cycle_limit) begin
      @(posedge CU_CLK);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/control_unit_testdata.txt */
# name opcode(hex) c z int alu_sel(hex) alu_strobes(bin: opy wr wr_sel[1:0] c_ld c_clr c_set z_ld ld_sel)
# pc_mux_sel(hex) scr_addr_sel(hex) flow_strobes(bin: pc_ld sp_inc sp_dec we data i_set i_clr shad)
add_rr    04 0 0 0 0 010010010 0 0 00000000
subc_rr   07 0 0 0 3 010010010 0 0 00000000
and_rr    00 0 0 0 5 010001010 0 0 00000000
exor_rr   02 0 0 0 7 010001010 0 0 00000000
cmp_rr    08 0 0 0 4 000010010 0 0 00000000
test_rr   03 0 0 0 8 000001010 0 0 00000000
mov_rr    09 0 0 0 e 010000000 0 0 00000000
lsl       20 0 0 0 9 010010010 0 0 00000000
ror       23 0 0 0 c 010010010 0 0 00000000
asr       24 0 0 0 d 010010010 0 0 00000000
and_ri_0  40 0 0 0 5 110001010 0 0 00000000
add_ri_1  51 0 0 0 0 110010010 0 0 00000000
cmp_ri_2  62 0 0 0 4 100010010 0 0 00000000
mov_ri_3  6f 0 0 0 e 110000000 0 0 00000000
brn       10 0 0 0 0 000000000 0 0 10000000
breq_z1   12 0 1 0 0 000000000 0 0 10000000
breq_z0   12 0 0 0 0 000000000 0 0 00000000
brne_z1   13 0 1 0 0 000000000 0 0 00000000
brcs_c1   14 1 0 0 0 000000000 0 0 10000000
brcc_c1   15 1 0 0 0 000000000 0 0 00000000
call      11 0 0 0 0 000000000 0 3 10111000
push      25 0 0 0 0 000000000 0 3 00110000
pop       26 0 0 0 0 010100000 0 2 01000000
ret       32 0 0 0 0 000000000 1 2 11000000
retid     36 0 0 0 0 000010011 1 2 11000010
retie     37 0 0 0 0 000010011 1 2 11000100
ld_rr     0a 0 0 0 0 010100000 0 0 00000000
ld_ri     72 0 0 0 0 010100000 0 1 00000000
st_rr     0b 0 0 0 0 000000000 0 0 00010000
st_ri     75 0 0 0 0 000000000 0 1 00010000
clc       30 0 0 0 0 000001000 0 0 00000000
sec       31 0 0 0 0 000000100 0 0 00000000
cli       35 0 0 0 0 000000000 0 0 00000010
sei       34 0 0 0 0 000000000 0 0 00000100
undef_7f  7f 1 1 0 0 000000000 0 0 00000000
add_int   04 0 0 1 0 010010010 0 0 00000000
brne_int  13 0 0 1 0 000000000 0 0 10000000
